/* hw/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// buffer geometry
`define ROB_DEPTH	16
`define ROB_IDX_W	4	// log2 of ROB_DEPTH

// instruction fields
`define PC_W		64
`define ARN_W		5
`define PRN_W		6	// 64 physical registers

// destination shown by an idle commit slot
`define ZERO_REG	31

`endif

/* hw/rob_pkg.sv */
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

	typedef logic [`ROB_IDX_W-1:0]	rob_idx_t;	// wraps modulo ROB_DEPTH
	typedef logic [`PC_W-1:0]		pc_t;
	typedef logic [`ARN_W-1:0]		arn_t;
	typedef logic [`PRN_W-1:0]		prn_t;

	// life of one buffer slot
	typedef enum logic [1:0] {
		ENTRY_FREE,
		ENTRY_WAITING,	// dispatched, result not back yet
		ENTRY_DONE
	} entry_state_e;

	// how many instructions leave the head this cycle
	typedef enum logic [1:0] {
		COMMIT_NONE,
		COMMIT_ONE,
		COMMIT_TWO
	} commit_kind_e;

endpackage

`default_nettype wire

/* hw/rob_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_entry import rob_pkg::*;
#(
	parameter int SLOT_INDEX = 0
)
(
	input  wire logic			clock,
	input  wire logic			reset,
	input  wire logic			load1,			// take the inst1 fields
	input  wire logic			load2,			// take the inst2 fields
	input  wire pc_t			inst1_pc,
	input  wire arn_t			inst1_arn_dest,
	input  wire prn_t			inst1_prn_dest,
	input  wire logic			inst1_is_branch,
	input  wire pc_t			inst2_pc,
	input  wire arn_t			inst2_arn_dest,
	input  wire prn_t			inst2_prn_dest,
	input  wire logic			inst2_is_branch,
	input  wire logic			complete_valid1,
	input  wire rob_idx_t		complete_idx1,
	input  wire logic			mispredict1,
	input  wire pc_t			target_pc1,
	input  wire logic			complete_valid2,
	input  wire rob_idx_t		complete_idx2,
	input  wire logic			mispredict2,
	input  wire pc_t			target_pc2,
	input  wire logic			retire,
	input  wire logic			flush,
	output entry_state_e		state,
	output pc_t					pc,
	output pc_t					target_pc,
	output arn_t				arn_dest,
	output prn_t				prn_dest,
	output logic				is_branch,
	output logic				mispredict
);

	logic hit1;
	logic hit2;

	// a result only lands on a slot that is still waiting for it
	assign hit1 = complete_valid1 && (complete_idx1 == rob_idx_t'(SLOT_INDEX))
		&& (state == ENTRY_WAITING);
	assign hit2 = complete_valid2 && (complete_idx2 == rob_idx_t'(SLOT_INDEX))
		&& (state == ENTRY_WAITING);

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= ENTRY_FREE;
		else if (flush || retire)
			state <= ENTRY_FREE;
		else if (load1 || load2)
			state <= ENTRY_WAITING;
		else if (hit1 || hit2)
			state <= ENTRY_DONE;
	end

	// instruction fields and result
	always_ff @(posedge clock)
	begin
		if (load1)
		begin
			pc			<= inst1_pc;
			arn_dest	<= inst1_arn_dest;
			prn_dest	<= inst1_prn_dest;
			is_branch	<= inst1_is_branch;
			mispredict	<= 1'b0;
			target_pc	<= '0;
		end
		else if (load2)
		begin
			pc			<= inst2_pc;
			arn_dest	<= inst2_arn_dest;
			prn_dest	<= inst2_prn_dest;
			is_branch	<= inst2_is_branch;
			mispredict	<= 1'b0;
			target_pc	<= '0;
		end
		else if (hit1)	// port 1 wins a tie
		begin
			mispredict	<= mispredict1;
			target_pc	<= target_pc1;
		end
		else if (hit2)
		begin
			mispredict	<= mispredict2;
			target_pc	<= target_pc2;
		end
	end

	// the allocator gives each slot to one dispatch lane only
	a_one_load: assert property (@(posedge clock) disable iff (reset) !(load1 && load2));

	// commit unit must never retire an instruction that has not finished
	a_retire_done: assert property (@(posedge clock) disable iff (reset)
		retire |-> state == ENTRY_DONE);

endmodule

`default_nettype wire

/* hw/rob_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_alloc import rob_pkg::*;
(
	input  wire logic					clock,
	input  wire logic					reset,
	input  wire logic					inst_pair_load,
	input  wire commit_kind_e			commit_kind,
	input  wire logic					flush,
	output logic [`ROB_DEPTH-1:0]		load1_vec,
	output logic [`ROB_DEPTH-1:0]		load2_vec,
	output rob_idx_t					inst1_rob_idx,
	output rob_idx_t					inst2_rob_idx,
	output logic						rob_full
);

	rob_idx_t				tail;
	logic [`ROB_IDX_W:0]	occupancy;		// 0 to ROB_DEPTH
	logic [`ROB_IDX_W:0]	n_retire;
	logic [`ROB_IDX_W:0]	n_taken;
	rob_idx_t				head_after;		// head once this cycle's commits are gone
	logic					take;

	// room for a whole pair means at most ROB_DEPTH-2 in use
	assign rob_full = occupancy > (`ROB_DEPTH - 2);
	assign take = inst_pair_load && !rob_full && !flush;

	assign inst1_rob_idx = tail;
	assign inst2_rob_idx = tail + 1'b1;

	always_comb
	begin
		case (commit_kind)
			COMMIT_ONE:	n_retire = 1;
			COMMIT_TWO:	n_retire = 2;
			default:	n_retire = 0;
		endcase
	end

	assign n_taken = take ? 2 : 0;
	assign head_after = tail - rob_idx_t'(occupancy) + rob_idx_t'(n_retire);

	// one strobe per lane, at tail and tail+1
	always_comb
	begin
		load1_vec = '0;
		load2_vec = '0;
		if (take)
		begin
			load1_vec[inst1_rob_idx] = 1'b1;
			load2_vec[inst2_rob_idx] = 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail		<= '0;
			occupancy	<= '0;
		end
		else if (flush)
		begin
			tail		<= head_after;	// drop everything younger than the branch
			occupancy	<= '0;
		end
		else
		begin
			tail		<= tail + rob_idx_t'(n_taken);
			occupancy	<= occupancy + n_taken - n_retire;
		end
	end

	// commits and dispatches together must keep the count inside the buffer
	a_occ_bound: assert property (@(posedge clock) disable iff (reset)
		occupancy <= `ROB_DEPTH);

endmodule

`default_nettype wire

/* hw/rob_commit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_commit import rob_pkg::*;
(
	input  wire logic				clock,
	input  wire logic				reset,
	input  wire entry_state_e		state [`ROB_DEPTH],
	input  wire pc_t				pc [`ROB_DEPTH],
	input  wire pc_t				target_pc [`ROB_DEPTH],
	input  wire arn_t				arn_dest [`ROB_DEPTH],
	input  wire prn_t				prn_dest [`ROB_DEPTH],
	input  wire logic				is_branch [`ROB_DEPTH],
	input  wire logic				mispredict [`ROB_DEPTH],
	output logic [`ROB_DEPTH-1:0]	retire_vec,
	output commit_kind_e			commit_kind,
	output logic					flush,
	output logic					commit1_valid,
	output pc_t						commit1_pc,
	output pc_t						commit1_target_pc,
	output logic					commit1_is_branch,
	output logic					commit1_mispredict,
	output arn_t					commit1_arn_dest,
	output prn_t					commit1_prn_dest,
	output logic					commit2_valid,
	output pc_t						commit2_pc,
	output pc_t						commit2_target_pc,
	output logic					commit2_is_branch,
	output logic					commit2_mispredict,
	output arn_t					commit2_arn_dest,
	output prn_t					commit2_prn_dest
);

	rob_idx_t head;
	rob_idx_t head_next;	// second oldest slot
	logic     head_bad;		// oldest is a mispredicted branch

	assign head_next = head + 1'b1;
	assign head_bad = is_branch[head] && mispredict[head];

	// an empty buffer has every slot free, so no tail compare is needed
	assign commit1_valid = state[head] == ENTRY_DONE;
	assign commit2_valid = commit1_valid && (state[head_next] == ENTRY_DONE) && !head_bad;

	always_comb
	begin
		commit1_pc			= '0;
		commit1_target_pc	= '0;
		commit1_is_branch	= 1'b0;
		commit1_mispredict	= 1'b0;
		commit1_arn_dest	= arn_t'(`ZERO_REG);
		commit1_prn_dest	= '0;
		commit2_pc			= '0;
		commit2_target_pc	= '0;
		commit2_is_branch	= 1'b0;
		commit2_mispredict	= 1'b0;
		commit2_arn_dest	= arn_t'(`ZERO_REG);
		commit2_prn_dest	= '0;
		retire_vec			= '0;
		if (commit1_valid)
		begin
			commit1_pc			= pc[head];
			commit1_target_pc	= target_pc[head];
			commit1_is_branch	= is_branch[head];
			commit1_mispredict	= mispredict[head];
			commit1_arn_dest	= arn_dest[head];
			commit1_prn_dest	= prn_dest[head];
			retire_vec[head]	= 1'b1;
		end
		if (commit2_valid)
		begin
			commit2_pc			= pc[head_next];
			commit2_target_pc	= target_pc[head_next];
			commit2_is_branch	= is_branch[head_next];
			commit2_mispredict	= mispredict[head_next];
			commit2_arn_dest	= arn_dest[head_next];
			commit2_prn_dest	= prn_dest[head_next];
			retire_vec[head_next] = 1'b1;
		end
	end

	always_comb
	begin
		if (commit2_valid)
			commit_kind = COMMIT_TWO;
		else if (commit1_valid)
			commit_kind = COMMIT_ONE;
		else
			commit_kind = COMMIT_NONE;
	end

	// a retiring wrong-path branch throws away every younger slot
	assign flush = (commit1_is_branch && commit1_mispredict)
		|| (commit2_is_branch && commit2_mispredict);

	always_ff @(posedge clock)
	begin
		if (reset)
			head <= '0;
		else if (commit2_valid)
			head <= head + 2'd2;
		else if (commit1_valid)
			head <= head_next;
	end

	// entries must all be free after a flush, so nothing retires next cycle
	a_flush_empty: assert property (@(posedge clock) disable iff (reset)
		flush |=> !commit1_valid);

endmodule

`default_nettype wire

/* hw/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_top import rob_pkg::*;
(
	input  wire logic		clock,
	input  wire logic		reset,
	input  wire logic		inst_pair_load,
	input  wire pc_t		inst1_pc,
	input  wire arn_t		inst1_arn_dest,
	input  wire prn_t		inst1_prn_dest,
	input  wire logic		inst1_is_branch,
	input  wire pc_t		inst2_pc,
	input  wire arn_t		inst2_arn_dest,
	input  wire prn_t		inst2_prn_dest,
	input  wire logic		inst2_is_branch,
	input  wire logic		complete_valid1,
	input  wire rob_idx_t	complete_idx1,
	input  wire logic		mispredict1,
	input  wire pc_t		target_pc1,
	input  wire logic		complete_valid2,
	input  wire rob_idx_t	complete_idx2,
	input  wire logic		mispredict2,
	input  wire pc_t		target_pc2,
	output rob_idx_t		inst1_rob_idx,
	output rob_idx_t		inst2_rob_idx,
	output logic			rob_full,
	output logic			commit1_valid,
	output pc_t				commit1_pc,
	output pc_t				commit1_target_pc,
	output logic			commit1_is_branch,
	output logic			commit1_mispredict,
	output arn_t			commit1_arn_dest,
	output prn_t			commit1_prn_dest,
	output logic			commit2_valid,
	output pc_t				commit2_pc,
	output pc_t				commit2_target_pc,
	output logic			commit2_is_branch,
	output logic			commit2_mispredict,
	output arn_t			commit2_arn_dest,
	output prn_t			commit2_prn_dest,
	output logic			flush
);

	logic [`ROB_DEPTH-1:0]	load1_vec;
	logic [`ROB_DEPTH-1:0]	load2_vec;
	logic [`ROB_DEPTH-1:0]	retire_vec;
	commit_kind_e			commit_kind;

	// per-slot views into the commit unit
	entry_state_e	slot_state [`ROB_DEPTH];
	pc_t			slot_pc [`ROB_DEPTH];
	pc_t			slot_target_pc [`ROB_DEPTH];
	arn_t			slot_arn_dest [`ROB_DEPTH];
	prn_t			slot_prn_dest [`ROB_DEPTH];
	logic			slot_is_branch [`ROB_DEPTH];
	logic			slot_mispredict [`ROB_DEPTH];

	rob_alloc u_alloc (
		.clock(clock), .reset(reset),
		.inst_pair_load(inst_pair_load),
		.commit_kind(commit_kind), .flush(flush),
		.load1_vec(load1_vec), .load2_vec(load2_vec),
		.inst1_rob_idx(inst1_rob_idx), .inst2_rob_idx(inst2_rob_idx),
		.rob_full(rob_full)
	);

	for (genvar i = 0; i < `ROB_DEPTH; i++)
	begin : g_slot
		rob_entry #(.SLOT_INDEX(i)) u_entry (
			.clock(clock), .reset(reset),
			.load1(load1_vec[i]), .load2(load2_vec[i]),
			.inst1_pc(inst1_pc), .inst1_arn_dest(inst1_arn_dest),
			.inst1_prn_dest(inst1_prn_dest), .inst1_is_branch(inst1_is_branch),
			.inst2_pc(inst2_pc), .inst2_arn_dest(inst2_arn_dest),
			.inst2_prn_dest(inst2_prn_dest), .inst2_is_branch(inst2_is_branch),
			.complete_valid1(complete_valid1), .complete_idx1(complete_idx1),
			.mispredict1(mispredict1), .target_pc1(target_pc1),
			.complete_valid2(complete_valid2), .complete_idx2(complete_idx2),
			.mispredict2(mispredict2), .target_pc2(target_pc2),
			.retire(retire_vec[i]), .flush(flush),
			.state(slot_state[i]), .pc(slot_pc[i]), .target_pc(slot_target_pc[i]),
			.arn_dest(slot_arn_dest[i]), .prn_dest(slot_prn_dest[i]),
			.is_branch(slot_is_branch[i]), .mispredict(slot_mispredict[i])
		);
	end

	rob_commit u_commit (
		.clock(clock), .reset(reset),
		.state(slot_state), .pc(slot_pc), .target_pc(slot_target_pc),
		.arn_dest(slot_arn_dest), .prn_dest(slot_prn_dest),
		.is_branch(slot_is_branch), .mispredict(slot_mispredict),
		.retire_vec(retire_vec), .commit_kind(commit_kind), .flush(flush),
		.commit1_valid(commit1_valid), .commit1_pc(commit1_pc),
		.commit1_target_pc(commit1_target_pc), .commit1_is_branch(commit1_is_branch),
		.commit1_mispredict(commit1_mispredict), .commit1_arn_dest(commit1_arn_dest),
		.commit1_prn_dest(commit1_prn_dest),
		.commit2_valid(commit2_valid), .commit2_pc(commit2_pc),
		.commit2_target_pc(commit2_target_pc), .commit2_is_branch(commit2_is_branch),
		.commit2_mispredict(commit2_mispredict), .commit2_arn_dest(commit2_arn_dest),
		.commit2_prn_dest(commit2_prn_dest)
	);

endmodule

`default_nettype wire

/* sim/rob_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_tb import rob_pkg::*;
();

	logic		clock;
	logic		reset;
	logic		inst_pair_load;
	pc_t		inst1_pc;
	arn_t		inst1_arn_dest;
	prn_t		inst1_prn_dest;
	logic		inst1_is_branch;
	pc_t		inst2_pc;
	arn_t		inst2_arn_dest;
	prn_t		inst2_prn_dest;
	logic		inst2_is_branch;
	logic		complete_valid1;
	rob_idx_t	complete_idx1;
	logic		mispredict1;
	pc_t		target_pc1;
	logic		complete_valid2;
	rob_idx_t	complete_idx2;
	logic		mispredict2;
	pc_t		target_pc2;
	rob_idx_t	inst1_rob_idx;
	rob_idx_t	inst2_rob_idx;
	logic		rob_full;
	logic		commit1_valid;
	pc_t		commit1_pc;
	pc_t		commit1_target_pc;
	logic		commit1_is_branch;
	logic		commit1_mispredict;
	arn_t		commit1_arn_dest;
	prn_t		commit1_prn_dest;
	logic		commit2_valid;
	pc_t		commit2_pc;
	pc_t		commit2_target_pc;
	logic		commit2_is_branch;
	logic		commit2_mispredict;
	arn_t		commit2_arn_dest;
	prn_t		commit2_prn_dest;
	logic		flush;

	// what was sent to each slot, filled when the trace says the pair is taken
	pc_t	rec_pc [`ROB_DEPTH];
	arn_t	rec_arn [`ROB_DEPTH];
	prn_t	rec_prn [`ROB_DEPTH];
	logic	rec_br [`ROB_DEPTH];

	// occupancy and program order as the trace should follow them
	int		model_head = 0;
	int		model_tail = 0;
	int		model_occ = 0;

	string	trace_lines [$];
	int		n_steps = 0;
	int		seq = 0;			// instruction number, gives unique fields
	int		step_errors;
	int		total_errors = 0;
	int		tests_failed = 0;

	rob_top u_rob_top (.*);

	always #20 clock = ~clock;

	function automatic pc_t target_for(input int slot, input int port);
		return pc_t'(64'hC000_0000) + pc_t'(slot * 256 + port);
	endfunction

	// high bits from the instruction number, low bits random
	function automatic pc_t fresh_pc(input int n);
		return (pc_t'(n + 'h100) << 16) | pc_t'($urandom & 32'hfffc);
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		$display("FAIL %s: got 0x%0h, expected 0x%0h", sig, got, exp);
		step_errors++;
	endtask

	task automatic check_index(input string sig, input rob_idx_t got, input rob_idx_t exp);
		if (got !== exp)
			report_mismatch(sig, 64'(got), 64'(exp));
	endtask

	task automatic check_flag(input string sig, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(sig, 64'(got), 64'(exp));
	endtask

	task automatic check_commit(input string lane, input logic got_v, input pc_t got_pc,
		input pc_t got_tgt, input arn_t got_arn, input prn_t got_prn, input logic got_br,
		input logic got_mp, input logic exp_v, input pc_t exp_pc, input pc_t exp_tgt,
		input arn_t exp_arn, input prn_t exp_prn, input logic exp_br, input logic exp_mp);
		if (got_v !== exp_v)
			report_mismatch({lane, "_valid"}, 64'(got_v), 64'(exp_v));
		if (got_pc !== exp_pc)
			report_mismatch({lane, "_pc"}, got_pc, exp_pc);
		if (got_tgt !== exp_tgt)
			report_mismatch({lane, "_target_pc"}, got_tgt, exp_tgt);
		if (got_arn !== exp_arn)
			report_mismatch({lane, "_arn_dest"}, 64'(got_arn), 64'(exp_arn));
		if (got_prn !== exp_prn)
			report_mismatch({lane, "_prn_dest"}, 64'(got_prn), 64'(exp_prn));
		if (got_br !== exp_br)
			report_mismatch({lane, "_is_branch"}, 64'(got_br), 64'(exp_br));
		if (got_mp !== exp_mp)
			report_mismatch({lane, "_mispredict"}, 64'(got_mp), 64'(exp_mp));
	endtask

	// steps the occupancy and order model and flags a trace line that leaves it
	task automatic track_model(input int ld, input int x_idx, input int x_full,
		input int x_flush, input int c1v, input int c1i, input int c1m, input int c2v,
		input int c2i, input int c2m);
		int n_ret;
		bit m_full;
		bit m_flush;
		n_ret = (c1v != 0) + (c2v != 0);
		m_full = model_occ > `ROB_DEPTH - 2;
		m_flush = (c1v != 0 && rec_br[c1i] && c1m != 0)
			|| (c2v != 0 && rec_br[c2i] && c2m != 0);
		if (x_idx != model_tail || x_full != m_full || x_flush != m_flush
			|| (c1v != 0 && c1i != model_head)
			|| (c2v != 0 && (c1v == 0 || c2i != (model_head + 1) % `ROB_DEPTH)))
		begin
			$display("trace step does not follow the occupancy and order model");
			step_errors++;
		end
		model_head = (model_head + n_ret) % `ROB_DEPTH;
		if (m_flush)
		begin
			model_tail = model_head;
			model_occ = 0;
		end
		else if (ld != 0 && !m_full)
		begin
			model_tail = (model_tail + 2) % `ROB_DEPTH;
			model_occ = model_occ + 2 - n_ret;
		end
		else
			model_occ = model_occ - n_ret;
	endtask

	task automatic load_trace(output bit ok);
		int fd;
		string line;
		ok = 0;
		fd = $fopen("sim/rob_trace.txt", "r");
		if (fd == 0)
			$display("could not open the trace file sim/rob_trace.txt");
		else
		begin
			while ($fgets(line, fd))
				if (line.len() > 1 && line[0] != "#")
					trace_lines.push_back(line);
			$fclose(fd);
			ok = trace_lines.size() > 0;
			if (!ok)
				$display("trace file holds no steps");
		end
	endtask

	// outputs depend on state only, so they are checked before this step's inputs go out
	task automatic run_step(input string line);
		string name;
		int ld, b1, b2, cv1, ci1, mp1, cv2, ci2, mp2, x_idx, x_full, x_flush;
		int c1v, c1i, c1m, c1p, c2v, c2i, c2m, c2p;
		int n;
		int slot2;
		@(negedge clock);
		step_errors = 0;
		n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
			name, ld, b1, b2, cv1, ci1, mp1, cv2, ci2, mp2, x_idx, x_full, x_flush,
			c1v, c1i, c1m, c1p, c2v, c2i, c2m, c2p);
		if (n != 21)
		begin
			$display("trace line could not be read: %s", line);
			step_errors++;
		end
		else
		begin
			check_index("inst1_rob_idx", inst1_rob_idx, rob_idx_t'(x_idx));
			check_index("inst2_rob_idx", inst2_rob_idx, rob_idx_t'(x_idx + 1));
			check_flag("rob_full", rob_full, x_full[0]);
			check_flag("flush", flush, x_flush[0]);
			if (c1v != 0)
				check_commit("commit1", commit1_valid, commit1_pc, commit1_target_pc,
					commit1_arn_dest, commit1_prn_dest, commit1_is_branch, commit1_mispredict,
					1'b1, rec_pc[c1i], target_for(c1i, c1p), rec_arn[c1i], rec_prn[c1i],
					rec_br[c1i], c1m[0]);
			else
				check_commit("commit1", commit1_valid, commit1_pc, commit1_target_pc,
					commit1_arn_dest, commit1_prn_dest, commit1_is_branch, commit1_mispredict,
					1'b0, '0, '0, arn_t'(`ZERO_REG), '0, 1'b0, 1'b0);
			if (c2v != 0)
				check_commit("commit2", commit2_valid, commit2_pc, commit2_target_pc,
					commit2_arn_dest, commit2_prn_dest, commit2_is_branch, commit2_mispredict,
					1'b1, rec_pc[c2i], target_for(c2i, c2p), rec_arn[c2i], rec_prn[c2i],
					rec_br[c2i], c2m[0]);
			else
				check_commit("commit2", commit2_valid, commit2_pc, commit2_target_pc,
					commit2_arn_dest, commit2_prn_dest, commit2_is_branch, commit2_mispredict,
					1'b0, '0, '0, arn_t'(`ZERO_REG), '0, 1'b0, 1'b0);
			track_model(ld, x_idx, x_full, x_flush, c1v, c1i, c1m, c2v, c2i, c2m);

			inst_pair_load = ld[0];
			inst1_pc = fresh_pc(seq);
			inst1_arn_dest = arn_t'(seq % 31);	// never the zero register
			inst1_prn_dest = prn_t'(seq % 64);
			inst1_is_branch = b1[0];
			inst2_pc = fresh_pc(seq + 1);
			inst2_arn_dest = arn_t'((seq + 1) % 31);
			inst2_prn_dest = prn_t'((seq + 1) % 64);
			inst2_is_branch = b2[0];
			seq += 2;
			complete_valid1 = cv1[0];
			complete_idx1 = rob_idx_t'(ci1);
			mispredict1 = mp1[0];
			target_pc1 = (cv1 != 0) ? target_for(ci1, 1) : '0;
			complete_valid2 = cv2[0];
			complete_idx2 = rob_idx_t'(ci2);
			mispredict2 = mp2[0];
			target_pc2 = (cv2 != 0) ? target_for(ci2, 2) : '0;

			// a pair is taken only when not full and not flushing
			if (ld != 0 && x_full == 0 && x_flush == 0)
			begin
				slot2 = (x_idx + 1) % `ROB_DEPTH;
				rec_pc[x_idx] = inst1_pc;
				rec_arn[x_idx] = inst1_arn_dest;
				rec_prn[x_idx] = inst1_prn_dest;
				rec_br[x_idx] = inst1_is_branch;
				rec_pc[slot2] = inst2_pc;
				rec_arn[slot2] = inst2_arn_dest;
				rec_prn[slot2] = inst2_prn_dest;
				rec_br[slot2] = inst2_is_branch;
			end
		end
		if (step_errors == 0)
			$display("step %-12s ok", name);
		else
		begin
			$display("step %-12s failed with %0d mismatches", name, step_errors);
			tests_failed++;
		end
		total_errors += step_errors;
	endtask

	initial
	begin
		bit ok;
		clock = 1'b0;
		reset = 1'b1;
		inst_pair_load = 1'b0;
		inst1_pc = '0;
		inst1_arn_dest = '0;
		inst1_prn_dest = '0;
		inst1_is_branch = 1'b0;
		inst2_pc = '0;
		inst2_arn_dest = '0;
		inst2_prn_dest = '0;
		inst2_is_branch = 1'b0;
		complete_valid1 = 1'b0;
		complete_idx1 = '0;
		mispredict1 = 1'b0;
		target_pc1 = '0;
		complete_valid2 = 1'b0;
		complete_idx2 = '0;
		mispredict2 = 1'b0;
		target_pc2 = '0;
		void'($urandom(97));
		load_trace(ok);
		n_steps = trace_lines.size();
		if (!ok)
		begin
			$display("run stopped without a usable trace");
			$display("ERRORS FOUND");
		end
		else
		begin
			repeat (3) @(posedge clock);
			@(negedge clock);
			reset = 1'b0;
			foreach (trace_lines[i])
				run_step(trace_lines[i]);
			@(negedge clock);
			$display("%0d tests, %0d passed, %0d failed, %0d mismatches", n_steps,
				n_steps - tests_failed, tests_failed, total_errors);
			if (total_errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
		end
		$finish;
	end

	// one clock per trace step plus a margin
	initial
	begin
		wait (n_steps > 0);
		#((n_steps + 50) * 40);
		$display("watchdog expired before the trace finished");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/rob_trace.txt */
# name ld br1 br2 | cv1 ci1 mp1 cv2 ci2 mp2 | idx1 full flush | c1v c1i c1m c1p c2v c2i c2m c2p
# inputs for one cycle, then outputs expected in it; cNi is the slot, cNp the port that completed it
reset_idle   0 0 0  0 0 0  0 0 0   0 0 0  0 0 0 0  0 0 0 0
disp_a       1 0 0  0 0 0  0 0 0   0 0 0  0 0 0 0  0 0 0 0
disp_b       1 0 0  0 0 0  0 0 0   2 0 0  0 0 0 0  0 0 0 0
comp_3_1     0 0 0  1 3 0  1 1 0   4 0 0  0 0 0 0  0 0 0 0
comp_0       0 0 0  1 0 0  0 0 0   4 0 0  0 0 0 0  0 0 0 0
retire_0_1   0 0 0  0 0 0  1 2 0   4 0 0  1 0 0 1  1 1 0 2
retire_2_3   0 0 0  0 0 0  0 0 0   4 0 0  1 2 0 2  1 3 0 1
fill_1       1 0 0  0 0 0  0 0 0   4 0 0  0 0 0 0  0 0 0 0
fill_2       1 1 0  0 0 0  0 0 0   6 0 0  0 0 0 0  0 0 0 0
fill_3       1 0 0  0 0 0  0 0 0   8 0 0  0 0 0 0  0 0 0 0
fill_4       1 0 0  0 0 0  0 0 0  10 0 0  0 0 0 0  0 0 0 0
fill_5       1 0 0  0 0 0  0 0 0  12 0 0  0 0 0 0  0 0 0 0
fill_6       1 0 0  0 0 0  0 0 0  14 0 0  0 0 0 0  0 0 0 0
fill_7       1 0 0  0 0 0  0 0 0   0 0 0  0 0 0 0  0 0 0 0
fill_8       1 0 0  0 0 0  0 0 0   2 0 0  0 0 0 0  0 0 0 0
full_drop    1 0 0  0 0 0  0 0 0   4 1 0  0 0 0 0  0 0 0 0
full_hold    1 0 0  0 0 0  0 0 0   4 1 0  0 0 0 0  0 0 0 0
tie_4        0 0 0  1 4 1  1 4 0   4 1 0  0 0 0 0  0 0 0 0
retire_4     0 0 0  1 5 0  1 7 0   4 1 0  1 4 1 1  0 0 0 0
retire_5     0 0 0  1 8 0  1 6 1   4 1 0  1 5 0 1  0 0 0 0
flush_head   1 0 0  0 0 0  0 0 0   4 0 1  1 6 1 2  0 0 0 0
after_flush  1 0 1  0 0 0  0 0 0   7 0 0  0 0 0 0  0 0 0 0
comp_7_8     1 0 0  1 7 0  1 8 1   9 0 0  0 0 0 0  0 0 0 0
flush_slot2  0 0 0  1 9 0  0 0 0  11 0 1  1 7 0 1  1 8 1 2
idle_end     0 0 0  0 0 0  0 0 0   9 0 0  0 0 0 0  0 0 0 0

/* tb.f */
+incdir+hw
hw/rob_pkg.sv
hw/rob_entry.sv
hw/rob_alloc.sv
hw/rob_commit.sv
hw/rob_top.sv
sim/rob_tb.sv
